// File: src.f
hw/exe_pkg.sv
hw/exe_mem_if.sv
hw/exe_alu.sv
hw/exe_fwd_unit.sv
hw/exe_stage.sv
hw/pipe_reg.sv
hw/mem_stage.sv
hw/exe_top.sv
tests/exe_checker.sv
tests/tb_exe_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_exe_top
FILELIST  := src.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
SRCS      := $(shell cat $(FILELIST))
PASS      := All checks passed

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJDIR)

// File: tests/tb_exe_top.sv
// Execute-end testbench
// Plays decode and the register file: issues a table of micro-ops with
// source values that lag two slots behind, and hands the expected
// results to the checker
`timescale 1ns/1ps

module tb_exe_top import exe_pkg::*; ();

	typedef struct packed {
		logic        enb;
		logic        kill;
		logic        valid;
		alu_op_t     op;
		brn_cnd_t    cnd;
		logic        op1_pc;
		logic        op2_imm;
		addr_base_t  base;
		wb_sel_t     wsel;
		logic        we;
		logic        ld;
		logic        st;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [31:0] imm;
	} row_t;

	logic        clk;
	logic        reset;
	logic        enb;
	logic        kill;
	logic        uop_valid;
	alu_op_t     alu_op;
	brn_cnd_t    brn_cnd;
	logic        op1_sel_pc;
	logic        op2_sel_imm;
	addr_base_t  addr_base;
	wb_sel_t     wb_sel;
	logic        we_reg;
	logic        mem_rd;
	logic        mem_wr;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [4:0]  rd;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] pc;
	logic [31:0] imm;
	logic        wb_valid;
	logic        wb_we;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;
	logic        brnch_taken;
	logic [31:0] brnch_target;
	logic        exp_wb_push;
	logic [37:0] exp_wb;
	logic        exp_br_taken;
	logic        exp_br_chk;
	logic [31:0] exp_br_target;
	int          errors;
	int          pending;
	logic        timed_out;

	row_t        tbl[$];
	logic [31:0] rf_true [32];
	logic [31:0] rf_arch [32];
	logic [31:0] mem_model [64];
	logic [4:0]  pend_rd[$];
	logic [31:0] pend_val[$];
	logic [31:0] rng;

	exe_top #(.DMEM_WORDS(64)) exe_top_i (.*);
	exe_checker check_i (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------
	function automatic logic [31:0] alu_ref(alu_op_t op, logic [31:0] a, logic [31:0] b);
		logic [4:0]  sh;
		logic [31:0] fill;
		sh = b[4:0];
		fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
		case (op)
			ALU_ADD:  return a + b;
			ALU_SUB:  return a + ~b + 32'd1;
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_SLL:  return a << sh;
			ALU_SRL:  return a >> sh;
			ALU_SRA:  return (a >> sh) | fill;
			ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
			ALU_SLTU: return {31'b0, a < b};
			ALU_LUI:  return b;
			default:  return 32'h0;
		endcase
	endfunction

	function automatic logic taken_ref(brn_cnd_t c, logic [31:0] a, logic [31:0] b);
		logic lt;
		lt = (a[31] != b[31]) ? a[31] : (a < b);
		case (c)
			BRN_EQ:  return a == b;
			BRN_NE:  return a != b;
			BRN_LT:  return lt;
			BRN_GE:  return !lt;
			BRN_LTU: return a < b;
			BRN_GEU: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// table rows
	// ----------------------------------------------------------------------
	function automatic row_t idle_row();
		row_t r;
		r = '0;
		r.enb = 1'b1;
		return r;
	endfunction

	function automatic row_t gap_row();
		return row_t'('0);
	endfunction

	function automatic row_t reg_op(alu_op_t op, logic [4:0] s1, logic [4:0] s2, logic [4:0] d);
		row_t r;
		r = idle_row();
		r.valid = 1'b1;
		r.we = 1'b1;
		r.op = op;
		r.rs1 = s1;
		r.rs2 = s2;
		r.rd = d;
		return r;
	endfunction

	function automatic row_t imm_op(alu_op_t op, logic [4:0] s1, logic [4:0] d, logic [31:0] i);
		row_t r;
		r = reg_op(op, s1, 5'd0, d);
		r.op2_imm = 1'b1;
		r.imm = i;
		return r;
	endfunction

	function automatic row_t store_op(logic [4:0] s1, logic [4:0] s2, logic [31:0] i);
		row_t r;
		r = reg_op(ALU_ADD, s1, s2, 5'd0);
		r.we = 1'b0;
		r.st = 1'b1;
		r.base = ADDR_SRC1;
		r.imm = i;
		return r;
	endfunction

	function automatic row_t load_op(logic [4:0] s1, logic [4:0] d, logic [31:0] i, wb_sel_t w);
		row_t r;
		r = reg_op(ALU_ADD, s1, 5'd0, d);
		r.ld = 1'b1;
		r.base = ADDR_SRC1;
		r.wsel = w;
		r.imm = i;
		return r;
	endfunction

	function automatic row_t branch_op(brn_cnd_t c, logic [4:0] s1, logic [4:0] s2,
		logic [31:0] i);
		row_t r;
		r = reg_op(ALU_ADD, s1, s2, 5'd0);
		r.we = 1'b0;
		r.cnd = c;
		r.imm = i;
		return r;
	endfunction

	// drive one row and advance the model by one slot when enabled
	task automatic apply_row(row_t r, logic [31:0] pc_v);
		logic [31:0] a, b, opa, opb, addr, res, cv;
		logic [4:0]  cr;
		logic [5:0]  idx;
		logic        live;
		a = rf_true[r.rs1];
		b = rf_true[r.rs2];
		opa = r.op1_pc ? pc_v : a;
		opb = r.op2_imm ? r.imm : b;
		case (r.base)
			ADDR_PC4:  addr = r.imm + pc_v + 32'd4;
			ADDR_SRC1: addr = r.imm + a;
			default:   addr = r.imm + pc_v;
		endcase
		idx = addr[7:2];
		case (r.wsel)
			WB_LOAD: res = mem_model[idx];
			WB_PC4:  res = pc_v + 32'd4;
			default: res = alu_ref(r.op, opa, opb);
		endcase
		live = r.valid && !r.kill;
		enb <= r.enb;
		kill <= r.kill;
		uop_valid <= r.valid;
		alu_op <= r.op;
		brn_cnd <= r.cnd;
		op1_sel_pc <= r.op1_pc;
		op2_sel_imm <= r.op2_imm;
		addr_base <= r.base;
		wb_sel <= r.wsel;
		we_reg <= r.we;
		mem_rd <= r.ld;
		mem_wr <= r.st;
		rs1 <= r.rs1;
		rs2 <= r.rs2;
		rd <= r.rd;
		src1 <= rf_arch[r.rs1];
		src2 <= rf_arch[r.rs2];
		pc <= pc_v;
		imm <= r.imm;
		exp_wb_push <= live;
		exp_wb <= {r.we, r.rd, res};
		exp_br_taken <= live && taken_ref(r.cnd, opa, opb);
		exp_br_chk <= live && (r.cnd != BRN_NONE);
		exp_br_target <= addr;
		if (r.enb) begin
			if (live && r.st)
				mem_model[idx] = b;
			if (live && r.we && r.rd != 5'd0)
				rf_true[r.rd] = res;
			pend_rd.push_back((live && r.we) ? r.rd : 5'd0);
			pend_val.push_back(res);
			// register file sees a write two slots late
			if (pend_rd.size() > 2) begin
				cr = pend_rd.pop_front();
				cv = pend_val.pop_front();
				if (cr != 5'd0)
					rf_arch[cr] = cv;
			end
		end
	endtask

	initial begin
		rng = 32'h9f6c;
		reset = 1'b1;
		timed_out = 1'b1;
		for (int i = 0; i < 32; i++) begin
			rf_true[i] = (i == 0) ? 32'h0 : next_rand();
			rf_arch[i] = rf_true[i];
		end
		for (int i = 0; i < 64; i++)
			mem_model[i] = 32'h0;

		// alu ops dependent at distance one and two
		tbl.push_back(reg_op(ALU_ADD, 5'd1, 5'd2, 5'd10));
		tbl.push_back(reg_op(ALU_SUB, 5'd10, 5'd3, 5'd11));
		tbl.push_back(reg_op(ALU_AND, 5'd4, 5'd10, 5'd12));
		tbl.push_back(reg_op(ALU_OR, 5'd11, 5'd12, 5'd13));
		tbl.push_back(reg_op(ALU_XOR, 5'd13, 5'd5, 5'd14));
		tbl.push_back(reg_op(ALU_SLL, 5'd6, 5'd7, 5'd15));
		tbl.push_back(reg_op(ALU_SRL, 5'd8, 5'd9, 5'd16));
		tbl.push_back(imm_op(ALU_LUI, 5'd0, 5'd18, 32'hf0f0_0000));
		tbl.push_back(reg_op(ALU_SRA, 5'd18, 5'd3, 5'd17));
		tbl.push_back(reg_op(ALU_SLT, 5'd18, 5'd2, 5'd19));
		tbl.push_back(reg_op(ALU_SLTU, 5'd1, 5'd2, 5'd20));
		tbl.push_back(gap_row());
		tbl.push_back(gap_row());
		// store, load back, use the load at once
		tbl.push_back(imm_op(ALU_ADD, 5'd0, 5'd5, 32'h40));
		tbl.push_back(store_op(5'd5, 5'd5, 32'h8));
		tbl.push_back(load_op(5'd5, 5'd21, 32'h8, WB_LOAD));
		tbl.push_back(reg_op(ALU_ADD, 5'd21, 5'd21, 5'd22));
		// flushed store must leave memory alone
		tbl.push_back(store_op(5'd0, 5'd22, 32'h10));
		tbl[tbl.size()-1].kill = 1'b1;
		tbl.push_back(load_op(5'd0, 5'd23, 32'h10, WB_LOAD));
		tbl.push_back(load_op(5'd0, 5'd24, 32'h20, WB_PC4));
		tbl.push_back(imm_op(ALU_ADD, 5'd1, 5'd0, 32'h5));
		tbl.push_back(reg_op(ALU_ADD, 5'd0, 5'd24, 5'd25));
		tbl.push_back(imm_op(ALU_ADD, 5'd0, 5'd26, 32'h100));
		tbl[tbl.size()-1].op1_pc = 1'b1;
		tbl.push_back(gap_row());
		// branch compares
		tbl.push_back(branch_op(BRN_EQ, 5'd25, 5'd24, 32'h20));
		tbl.push_back(branch_op(BRN_NE, 5'd1, 5'd2, 32'hffff_fff8));
		tbl.push_back(branch_op(BRN_LT, 5'd18, 5'd1, 32'h40));
		tbl.push_back(branch_op(BRN_GE, 5'd1, 5'd18, 32'h10));
		tbl.push_back(branch_op(BRN_LTU, 5'd18, 5'd1, 32'h8));
		tbl.push_back(branch_op(BRN_GEU, 5'd0, 5'd1, 32'h4));

		apply_row(gap_row(), 32'h0);
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < tbl.size(); i++) begin
			@(posedge clk);
			apply_row(tbl[i], 32'h100 + 32'(i) * 32'd4);
		end
		// drain the pipeline with bubbles
		for (int t = 0; t < 40; t++) begin
			@(posedge clk);
			apply_row(idle_row(), 32'h0);
			if (t >= 2 && pending == 0) begin
				timed_out = 1'b0;
				break;
			end
		end

		if (timed_out)
			$display("timeout: expected writebacks never arrived");
		check_i.print_summary();
		if (!timed_out && errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: tests/exe_checker.sv
// Execute-end checker
// Watches the writeback and branch ports, compares them with the
// expected values the testbench hands over, and checks that outputs
// hold while enb is low
`timescale 1ns/1ps

module exe_checker (
	input  logic        clk,
	input  logic        reset,
	input  logic        enb,
	input  logic        exp_wb_push,
	input  logic [37:0] exp_wb,
	input  logic        exp_br_taken,
	input  logic        exp_br_chk,
	input  logic [31:0] exp_br_target,
	input  logic        wb_valid,
	input  logic        wb_we,
	input  logic [4:0]  wb_rd,
	input  logic [31:0] wb_data,
	input  logic        brnch_taken,
	input  logic [31:0] brnch_target,
	output int          errors,
	output int          pending
);

	logic        cap_rst;
	logic        cap_en;
	logic        cap_push;
	logic [37:0] cap_wb;
	logic        cap_taken;
	logic        cap_chk;
	logic [31:0] cap_target;
	logic [71:0] snap;
	logic [71:0] now_v;
	logic [37:0] exp_q[$];
	int          stamp_q[$];
	int          err_cnt = 0;
	int          pend_cnt = 0;
	int          en_cnt = 0;
	int          n_wb = 0;
	int          n_br = 0;

	assign errors  = err_cnt;
	assign pending = pend_cnt;
	assign now_v   = {wb_valid, wb_we, wb_rd, wb_data, brnch_taken, brnch_target};

	// what the DUT saw at this edge
	always @(posedge clk) begin
		cap_rst    <= reset;
		cap_en     <= enb && !reset;
		cap_push   <= exp_wb_push && enb && !reset;
		cap_wb     <= exp_wb;
		cap_taken  <= exp_br_taken;
		cap_chk    <= exp_br_chk;
		cap_target <= exp_br_target;
	end

	// ----------------------------------------------------------------------
	// compare at the falling edge where outputs are settled
	// ----------------------------------------------------------------------
	always @(negedge clk) begin
		logic [37:0] e;
		int          stamp;
		if (cap_en) begin
			en_cnt++;
			if (cap_push) begin
				exp_q.push_back(cap_wb);
				stamp_q.push_back(en_cnt);
			end
			n_br++;
			if (brnch_taken !== cap_taken) begin
				err_cnt++;
				$display("ERR %0t: brnch_taken %b, expected %b", $time, brnch_taken, cap_taken);
			end
			if (cap_chk && brnch_target !== cap_target) begin
				err_cnt++;
				$display("ERR %0t: brnch_target %h, expected %h", $time, brnch_target,
					cap_target);
			end
			if (wb_valid) begin
				if (exp_q.size() == 0) begin
					err_cnt++;
					$display("ERR %0t: unexpected writeback to x%0d", $time, wb_rd);
				end else begin
					e = exp_q.pop_front();
					stamp = stamp_q.pop_front();
					n_wb++;
					if ({wb_we, wb_rd, wb_data} !== e) begin
						err_cnt++;
						$display("ERR %0t: writeback we=%b x%0d=%h, expected we=%b x%0d=%h",
							$time, wb_we, wb_rd, wb_data, e[37], e[36:32], e[31:0]);
					end
					if (en_cnt != stamp + 1) begin
						err_cnt++;
						$display("ERR %0t: writeback of x%0d after %0d enabled cycles, expected 2",
							$time, wb_rd, en_cnt - stamp + 1);
					end
				end
			end
		end else if (!cap_rst && now_v !== snap) begin
			err_cnt++;
			$display("ERR %0t: outputs changed while enb was low", $time);
		end
		snap = now_v;
		pend_cnt = exp_q.size();
	end

	task print_summary();
		$display("checker: %0d writebacks, %0d branch checks, %0d left over, %0d errors",
			n_wb, n_br, pend_cnt, err_cnt);
	endtask

endmodule

// File: hw/exe_top.sv
// Execute-end top level
// Execute stage, exe/mem register, memory stage and mem/wb register
// with the forwarding unit closing the bypass loop
`timescale 1ns/1ps

module exe_top import exe_pkg::*; #(
	parameter int DMEM_WORDS = 64
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            enb,
	input  logic            kill,
	input  logic            uop_valid,
	input  alu_op_t         alu_op,
	input  brn_cnd_t        brn_cnd,
	input  logic            op1_sel_pc,
	input  logic            op2_sel_imm,
	input  addr_base_t      addr_base,
	input  wb_sel_t         wb_sel,
	input  logic            we_reg,
	input  logic            mem_rd,
	input  logic            mem_wr,
	input  logic [4:0]      rs1,
	input  logic [4:0]      rs2,
	input  logic [4:0]      rd,
	input  logic [XLEN-1:0] src1,
	input  logic [XLEN-1:0] src2,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] imm,
	output logic            wb_valid,
	output logic            wb_we,
	output logic [4:0]      wb_rd,
	output logic [XLEN-1:0] wb_data,
	output logic            brnch_taken,
	output logic [XLEN-1:0] brnch_target
);

	fwd_sel_t        fwd1, fwd2;
	exe_mem_t        exe_d, em_q;
	mem_wb_t         mw_d, mw_q;
	logic [XLEN-1:0] mem_result;

	exe_mem_if em_bus ();

	exe_fwd_unit fwd_i (
		.rs1 (rs1), .rs2 (rs2),
		.mem_rd (em_q.rd), .mem_we (em_q.we_reg), .mem_valid (em_q.valid),
		.wb_rd (mw_q.rd), .wb_we (mw_q.we_reg), .wb_valid (mw_q.valid),
		.fwd1 (fwd1), .fwd2 (fwd2)
	);

	exe_stage exe_i (
		.uop_valid (uop_valid), .alu_op (alu_op), .brn_cnd (brn_cnd),
		.op1_sel_pc (op1_sel_pc), .op2_sel_imm (op2_sel_imm),
		.addr_base (addr_base), .wb_sel (wb_sel), .we_reg (we_reg),
		.mem_rd (mem_rd), .mem_wr (mem_wr), .rd (rd),
		.src1 (src1), .src2 (src2), .pc (pc), .imm (imm),
		.fwd1 (fwd1), .fwd2 (fwd2),
		.mem_fwd_data (mem_result), .wb_fwd_data (mw_q.result),
		.exe_out (exe_d)
	);

	pipe_reg #(.PAYLOAD_T(exe_mem_t)) exe_mem_reg_i (
		.clk (clk), .reset (reset), .enb (enb), .kill (kill), .d (exe_d), .q (em_q)
	);

	assign em_bus.pl = em_q;

	mem_stage #(.DMEM_WORDS(DMEM_WORDS)) mem_i (
		.clk (clk), .reset (reset), .enb (enb), .em (em_bus.dst),
		.mem_result (mem_result), .wb_out (mw_d)
	);

	// kill only flushes the entry entering exe/mem
	pipe_reg #(.PAYLOAD_T(mem_wb_t)) mem_wb_reg_i (
		.clk (clk), .reset (reset), .enb (enb), .kill (1'b0), .d (mw_d), .q (mw_q)
	);

	assign wb_valid     = mw_q.valid;
	assign wb_we        = mw_q.we_reg;
	assign wb_rd        = mw_q.rd;
	assign wb_data      = mw_q.result;
	assign brnch_taken  = em_q.brnch_taken;
	assign brnch_target = em_q.addr;

endmodule

// File: hw/mem_stage.sv
// Memory stage
// Word data RAM with asynchronous read, store qualified by enb, and the
// writeback select that packs the mem/wb payload
`timescale 1ns/1ps

module mem_stage import exe_pkg::*; #(
	parameter int DMEM_WORDS = 64
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            enb,
	exe_mem_if.dst          em,
	output logic [XLEN-1:0] mem_result,
	output mem_wb_t         wb_out
);

	// depth is a power of two, so the slice is the index modulo depth
	localparam int AW = $clog2(DMEM_WORDS);

	logic [XLEN-1:0] dmem [DMEM_WORDS];
	logic [AW-1:0]   widx;
	logic            store_en;
	logic [XLEN-1:0] load_data;

	assign widx      = em.pl.addr[2 +: AW];
	assign store_en  = enb && em.pl.valid && em.pl.mem_wr;
	assign load_data = dmem[widx];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= '0;
		end else if (store_en) begin
			dmem[widx] <= em.pl.store_data;
		end
	end

	// ----------------------------------------------------------------------
	// writeback select
	// ----------------------------------------------------------------------
	always_comb begin
		case (em.pl.wb_sel)
			WB_LOAD: mem_result = load_data;
			WB_PC4:  mem_result = em.pl.pc_4;
			default: mem_result = em.pl.alu_result;
		endcase
	end

	assign wb_out.valid  = em.pl.valid;
	assign wb_out.we_reg = em.pl.we_reg;
	assign wb_out.rd     = em.pl.rd;
	assign wb_out.result = mem_result;

	// address comes from the execute adder one cycle earlier
	a_store_aligned: assert property (@(posedge clk) disable iff (reset)
		(em.pl.valid && em.pl.mem_wr) |-> (em.pl.addr[1:0] == 2'b00))
		else $error("misaligned store address");

endmodule

// File: hw/pipe_reg.sv
// Pipeline register
// Loads its payload on enb; reset and kill turn it into an all-zero
// bubble, kill taking priority over enb
`timescale 1ns/1ps

module pipe_reg #(
	parameter type PAYLOAD_T = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     enb,
	input  logic     kill,
	input  PAYLOAD_T d,
	output PAYLOAD_T q
);

	always_ff @(posedge clk) begin
		if (reset || kill) begin
			q <= '0;
		end else if (enb) begin
			q <= d;
		end
	end

endmodule

// File: hw/exe_stage.sv
// Execute stage
// Bypass muxes on both sources, pc/immediate operand selects, the ALU,
// the address adder and packing of the exe/mem payload
`timescale 1ns/1ps

module exe_stage import exe_pkg::*; (
	input  logic            uop_valid,
	input  alu_op_t         alu_op,
	input  brn_cnd_t        brn_cnd,
	input  logic            op1_sel_pc,
	input  logic            op2_sel_imm,
	input  addr_base_t      addr_base,
	input  wb_sel_t         wb_sel,
	input  logic            we_reg,
	input  logic            mem_rd,
	input  logic            mem_wr,
	input  logic [4:0]      rd,
	input  logic [XLEN-1:0] src1,
	input  logic [XLEN-1:0] src2,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] imm,
	input  fwd_sel_t        fwd1,
	input  fwd_sel_t        fwd2,
	input  logic [XLEN-1:0] mem_fwd_data,
	input  logic [XLEN-1:0] wb_fwd_data,
	output exe_mem_t        exe_out
);

	logic [XLEN-1:0] op1, op2;
	logic [XLEN-1:0] alu_a, alu_b;
	logic [XLEN-1:0] alu_result;
	logic            brnch_taken;
	logic [XLEN-1:0] pc_4;
	logic [XLEN-1:0] addr_base_val;

	// ----------------------------------------------------------------------
	// operand bypass
	// ----------------------------------------------------------------------
	assign op1 = (fwd1 == FWD_MEM) ? mem_fwd_data :
	             (fwd1 == FWD_WB)  ? wb_fwd_data  : src1;
	assign op2 = (fwd2 == FWD_MEM) ? mem_fwd_data :
	             (fwd2 == FWD_WB)  ? wb_fwd_data  : src2;

	assign alu_a = op1_sel_pc  ? pc  : op1;
	assign alu_b = op2_sel_imm ? imm : op2;

	exe_alu alu_i (
		.src1        (alu_a),
		.src2        (alu_b),
		.alu_op      (alu_op),
		.brn_cnd     (brn_cnd),
		.alu_result  (alu_result),
		.brnch_taken (brnch_taken)
	);

	// ----------------------------------------------------------------------
	// address adder
	// ----------------------------------------------------------------------
	assign pc_4 = pc + 32'd4;

	always_comb begin
		case (addr_base)
			ADDR_PC4:  addr_base_val = pc_4;
			ADDR_SRC1: addr_base_val = op1;
			default:   addr_base_val = pc;
		endcase
	end

	always_comb begin
		exe_out             = '0;
		exe_out.valid       = uop_valid;
		exe_out.we_reg      = we_reg;
		exe_out.rd          = rd;
		exe_out.wb_sel      = wb_sel;
		exe_out.mem_rd      = mem_rd;
		exe_out.mem_wr      = mem_wr;
		exe_out.alu_result  = alu_result;
		exe_out.addr        = imm + addr_base_val;
		// store data takes the bypassed value, not the stale one
		exe_out.store_data  = op2;
		exe_out.pc_4        = pc_4;
		exe_out.brnch_taken = uop_valid && brnch_taken;
	end

	// a micro-op never loads and stores at once
	always_comb begin
		if (uop_valid && mem_rd)
			assert (!mem_wr) else $error("micro-op is both load and store");
	end

endmodule

// File: hw/exe_fwd_unit.sv
// Forwarding unit
// Picks the youngest in-flight producer of each source register,
// memory stage first, then writeback; x0 is never bypassed
`timescale 1ns/1ps

module exe_fwd_unit import exe_pkg::*; (
	input  logic [4:0] rs1,
	input  logic [4:0] rs2,
	input  logic [4:0] mem_rd,
	input  logic       mem_we,
	input  logic       mem_valid,
	input  logic [4:0] wb_rd,
	input  logic       wb_we,
	input  logic       wb_valid,
	output fwd_sel_t   fwd1,
	output fwd_sel_t   fwd2
);

	logic mem_hit1, mem_hit2;
	logic wb_hit1, wb_hit2;

	assign mem_hit1 = mem_valid && mem_we && (mem_rd != 5'd0) && (mem_rd == rs1);
	assign mem_hit2 = mem_valid && mem_we && (mem_rd != 5'd0) && (mem_rd == rs2);
	assign wb_hit1  = wb_valid && wb_we && (wb_rd != 5'd0) && (wb_rd == rs1);
	assign wb_hit2  = wb_valid && wb_we && (wb_rd != 5'd0) && (wb_rd == rs2);

	// an older writeback value must never shadow a younger memory-stage one
	assign fwd1 = mem_hit1 ? FWD_MEM : (wb_hit1 ? FWD_WB : FWD_REG);
	assign fwd2 = mem_hit2 ? FWD_MEM : (wb_hit2 ? FWD_WB : FWD_REG);

endmodule

// File: hw/exe_alu.sv
// Integer ALU
// Arithmetic, logic and shift result plus a separate branch compare
// on the same two operands
`timescale 1ns/1ps

module exe_alu import exe_pkg::*; (
	input  logic [XLEN-1:0] src1,
	input  logic [XLEN-1:0] src2,
	input  alu_op_t         alu_op,
	input  brn_cnd_t        brn_cnd,
	output logic [XLEN-1:0] alu_result,
	output logic            brnch_taken
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = src2[4:0];
	assign lt_s  = $signed(src1) < $signed(src2);
	assign lt_u  = src1 < src2;

	always_comb begin
		case (alu_op)
			ALU_ADD:  alu_result = src1 + src2;
			ALU_SUB:  alu_result = src1 - src2;
			ALU_AND:  alu_result = src1 & src2;
			ALU_OR:   alu_result = src1 | src2;
			ALU_XOR:  alu_result = src1 ^ src2;
			ALU_SLL:  alu_result = src1 << shamt;
			ALU_SRL:  alu_result = src1 >> shamt;
			ALU_SRA:  alu_result = $unsigned($signed(src1) >>> shamt);
			ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, lt_s};
			ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, lt_u};
			// upper immediate already shifted by decode
			ALU_LUI:  alu_result = src2;
			default:  alu_result = '0;
		endcase
	end

	// compare is independent of alu_op
	always_comb begin
		case (brn_cnd)
			BRN_EQ:  brnch_taken = (src1 == src2);
			BRN_NE:  brnch_taken = (src1 != src2);
			BRN_LT:  brnch_taken = lt_s;
			BRN_GE:  brnch_taken = !lt_s;
			BRN_LTU: brnch_taken = lt_u;
			BRN_GEU: brnch_taken = !lt_u;
			default: brnch_taken = 1'b0;
		endcase
	end

endmodule

// File: hw/exe_mem_if.sv
// Exe/mem link
// Carries the registered exe/mem payload from the pipeline register
// to the memory stage
`timescale 1ns/1ps

interface exe_mem_if import exe_pkg::*; ();

	exe_mem_t pl;

	// register side
	modport src (
		output pl
	);

	// memory stage side
	modport dst (
		input pl
	);

endinterface

// File: hw/exe_pkg.sv
// Execute-end package
// Opcode encodings, operand and writeback selects, and the payload
// structs carried by the exe/mem and mem/wb pipeline registers
package exe_pkg;

	localparam int XLEN = 32;

	// ----------------------------------------------------------------------
	// operation encodings
	// ----------------------------------------------------------------------
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_SLT  = 4'd8,
		ALU_SLTU = 4'd9,
		ALU_LUI  = 4'd10
	} alu_op_t;

	// none means not a branch
	typedef enum logic [2:0] {
		BRN_NONE = 3'd0,
		BRN_EQ   = 3'd1,
		BRN_NE   = 3'd2,
		BRN_LT   = 3'd3,
		BRN_GE   = 3'd4,
		BRN_LTU  = 3'd5,
		BRN_GEU  = 3'd6
	} brn_cnd_t;

	typedef enum logic [1:0] {FWD_REG = 2'd0, FWD_MEM = 2'd1, FWD_WB = 2'd2} fwd_sel_t;
	typedef enum logic [1:0] {ADDR_PC = 2'd0, ADDR_PC4 = 2'd1, ADDR_SRC1 = 2'd2} addr_base_t;
	typedef enum logic [1:0] {WB_ALU = 2'd0, WB_LOAD = 2'd1, WB_PC4 = 2'd2} wb_sel_t;

	// ----------------------------------------------------------------------
	// pipeline payloads
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic            valid;
		logic            we_reg;
		logic [4:0]      rd;
		wb_sel_t         wb_sel;
		logic            mem_rd;
		logic            mem_wr;
		logic [XLEN-1:0] alu_result;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] store_data;
		logic [XLEN-1:0] pc_4;
		logic            brnch_taken;
	} exe_mem_t;

	typedef struct packed {
		logic            valid;
		logic            we_reg;
		logic [4:0]      rd;
		logic [XLEN-1:0] result;
	} mem_wb_t;

endpackage
